// ==== design/cpu_pkg.sv ====
package cpu_pkg;

	localparam logic [31:0] reset_pc = 32'h0000_3000;

	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J = 6'h02;
	localparam logic [5:0] OP_JAL = 6'h03;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_BNE = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_LUI = 6'h0f;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;

	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_JR = 6'h08;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	// Next-PC source chosen by the instruction in D
	localparam logic [2:0] JMP_SEQ = 3'd0;
	localparam logic [2:0] JMP_BEQ = 3'd1;
	localparam logic [2:0] JMP_BNE = 3'd2;
	localparam logic [2:0] JMP_J = 3'd3;
	localparam logic [2:0] JMP_JR = 3'd4;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instr_t;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_LUI} alu_op_e;
	typedef enum logic [1:0] {FWD_ORIG, FWD_FROM_E, FWD_FROM_M, FWD_FROM_W} fwd_sel_e;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_RETADDR} wb_sel_e;

	typedef struct packed {
		logic [4:0] dest;
		alu_op_e alu_op;
		logic alu_src; // Immediate as ALU operand b
		wb_sel_e wb_sel;
		logic mem_read;
		logic mem_write;
		logic reg_write;
	} ctrl_t;

	typedef struct packed {
		logic [31:0] pc;
		instr_t instr;
	} dstage_t;

	typedef struct packed {
		logic [31:0] pc;
		instr_t instr;
		logic [31:0] op1;
		logic [31:0] op2;
		logic [31:0] imm;
		ctrl_t ctrl;
	} estage_t;

	typedef struct packed {
		logic [31:0] pc;
		instr_t instr;
		logic [31:0] alu_result;
		logic [31:0] store_data;
		logic [4:0] dest;
		wb_sel_e wb_sel;
		logic mem_read;
		logic mem_write;
		logic reg_write;
	} mstage_t;

	typedef struct packed {
		logic [31:0] pc;
		instr_t instr;
		logic [31:0] alu_result;
		logic [31:0] load_data;
		logic [4:0] dest;
		wb_sel_e wb_sel;
		logic reg_write;
	} wstage_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic we;
		logic stop; // Access pending in M
	} mem_req_t;

	typedef struct packed {
		logic valid;
		logic [31:0] pc;
		logic [4:0] addr;
		logic [31:0] data;
	} wb_trace_t;

endpackage

// ==== design/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic [31:0]
) (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic flush,
	input payload_t d,
	output payload_t q
);

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			q <= '0; // All-zero payload is sll zero, a nop
		end else if (enable) begin
			q <= d;
		end
	end

endmodule

// ==== design/regfile.sv ====
`timescale 1ns/1ps

module regfile (
	input logic clk,
	input logic reset,
	input logic [4:0] raddr1,
	input logic [4:0] raddr2,
	input logic [4:0] waddr,
	input logic [31:0] wdata,
	input logic we,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// Same-cycle write is visible to the read in D
	assign rdata1 = (raddr1 == 5'd0) ? 32'h0 :
		(we && waddr == raddr1) ? wdata : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? 32'h0 :
		(we && waddr == raddr2) ? wdata : regs[raddr2];

	// Decode must never enable a write to $zero
	a_no_zero_write: assert property (@(posedge clk) disable iff (reset)
		!(we && waddr == 5'd0));

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu (
	input logic [31:0] a,
	input logic [31:0] b,
	input cpu_pkg::alu_op_e op,
	output logic [31:0] result
);

	always_comb begin
		case (op)
			cpu_pkg::ALU_ADD: result = a + b;
			cpu_pkg::ALU_SUB: result = a - b;
			cpu_pkg::ALU_AND: result = a & b;
			cpu_pkg::ALU_OR: result = a | b;
			cpu_pkg::ALU_SLT: result = {31'h0, $signed(a) < $signed(b)};
			cpu_pkg::ALU_LUI: result = {b[15:0], 16'h0};
			default: result = 32'h0;
		endcase
	end

	always_comb begin
		a_op_defined: assert #0 (op inside {cpu_pkg::ALU_ADD, cpu_pkg::ALU_SUB,
			cpu_pkg::ALU_AND, cpu_pkg::ALU_OR, cpu_pkg::ALU_SLT, cpu_pkg::ALU_LUI});
	end

endmodule

// ==== design/control.sv ====
`timescale 1ns/1ps

module control (
	input cpu_pkg::instr_t d_instr,
	input cpu_pkg::instr_t e_instr,
	input cpu_pkg::instr_t m_instr,
	input cpu_pkg::instr_t w_instr,
	input logic bridge_valid,
	output logic hold,
	output logic pc_enable,
	output logic d_enable,
	output logic e_flush,
	output cpu_pkg::fwd_sel_e fwd_d1,
	output cpu_pkg::fwd_sel_e fwd_d2,
	output cpu_pkg::fwd_sel_e fwd_e1,
	output cpu_pkg::fwd_sel_e fwd_e2,
	output cpu_pkg::fwd_sel_e fwd_m,
	output cpu_pkg::ctrl_t e_ctrl,
	output logic [2:0] jump_mode
);

	function automatic cpu_pkg::ctrl_t decode(cpu_pkg::instr_t i);
		cpu_pkg::ctrl_t c;
		c = '0;
		c.dest = i.rt;
		c.reg_write = 1'b1;
		case (i.op)
			cpu_pkg::OP_RTYPE: begin
				c.dest = i.rd;
				case (i.funct)
					cpu_pkg::FN_ADDU: c.alu_op = cpu_pkg::ALU_ADD;
					cpu_pkg::FN_SUBU: c.alu_op = cpu_pkg::ALU_SUB;
					cpu_pkg::FN_AND: c.alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::FN_OR: c.alu_op = cpu_pkg::ALU_OR;
					cpu_pkg::FN_SLT: c.alu_op = cpu_pkg::ALU_SLT;
					default: c.reg_write = 1'b0; // jr and the sll nop
				endcase
			end
			cpu_pkg::OP_ADDIU: c.alu_src = 1'b1;
			cpu_pkg::OP_ORI: begin
				c.alu_src = 1'b1;
				c.alu_op = cpu_pkg::ALU_OR;
			end
			cpu_pkg::OP_LUI: begin
				c.alu_src = 1'b1;
				c.alu_op = cpu_pkg::ALU_LUI;
			end
			cpu_pkg::OP_LW: begin
				c.alu_src = 1'b1;
				c.mem_read = 1'b1;
				c.wb_sel = cpu_pkg::WB_MEM;
			end
			cpu_pkg::OP_SW: begin
				c.alu_src = 1'b1;
				c.mem_write = 1'b1;
				c.reg_write = 1'b0;
			end
			cpu_pkg::OP_JAL: begin
				c.dest = 5'd31;
				c.wb_sel = cpu_pkg::WB_RETADDR;
			end
			default: c.reg_write = 1'b0;
		endcase
		if (c.dest == 5'd0) c.reg_write = 1'b0;
		return c;
	endfunction

	// Youngest producer wins; D only takes from E when E is jal
	function automatic cpu_pkg::fwd_sel_e pick(logic [4:0] r, cpu_pkg::ctrl_t e,
		cpu_pkg::ctrl_t m, cpu_pkg::ctrl_t w, logic use_e);
		if (r == 5'd0) return cpu_pkg::FWD_ORIG;
		if (use_e && e.reg_write && e.dest == r)
			return (e.wb_sel == cpu_pkg::WB_RETADDR) ?
				cpu_pkg::FWD_FROM_E : cpu_pkg::FWD_ORIG;
		if (m.reg_write && m.dest == r)
			return (use_e || m.wb_sel != cpu_pkg::WB_MEM) ?
				cpu_pkg::FWD_FROM_M : cpu_pkg::FWD_ORIG;
		if (w.reg_write && w.dest == r) return cpu_pkg::FWD_FROM_W;
		return cpu_pkg::FWD_ORIG;
	endfunction

	cpu_pkg::ctrl_t e_c, m_c, w_c;
	logic uses_rs, uses_rt, branch, hit, stall;

	assign e_ctrl = decode(d_instr);
	assign e_c = decode(e_instr);
	assign m_c = decode(m_instr);
	assign w_c = decode(w_instr);

	always_comb begin
		case (d_instr.op)
			cpu_pkg::OP_BEQ: jump_mode = cpu_pkg::JMP_BEQ;
			cpu_pkg::OP_BNE: jump_mode = cpu_pkg::JMP_BNE;
			cpu_pkg::OP_J, cpu_pkg::OP_JAL: jump_mode = cpu_pkg::JMP_J;
			cpu_pkg::OP_RTYPE: jump_mode = (d_instr.funct == cpu_pkg::FN_JR) ?
				cpu_pkg::JMP_JR : cpu_pkg::JMP_SEQ;
			default: jump_mode = cpu_pkg::JMP_SEQ;
		endcase
	end

	// Store data of sw is left to fwd_m in M
	assign uses_rs = d_instr.op != cpu_pkg::OP_J && d_instr.op != cpu_pkg::OP_JAL &&
		d_instr.op != cpu_pkg::OP_LUI;
	assign uses_rt = jump_mode == cpu_pkg::JMP_BEQ || jump_mode == cpu_pkg::JMP_BNE ||
		(d_instr.op == cpu_pkg::OP_RTYPE && e_ctrl.reg_write);
	assign branch = jump_mode == cpu_pkg::JMP_BEQ || jump_mode == cpu_pkg::JMP_BNE ||
		jump_mode == cpu_pkg::JMP_JR;
	assign hit = e_c.reg_write && ((uses_rs && d_instr.rs == e_c.dest) ||
		(uses_rt && d_instr.rt == e_c.dest));
	assign stall = hit && (e_c.mem_read || (branch && e_c.wb_sel != cpu_pkg::WB_RETADDR));

	assign hold = (m_c.mem_read || m_c.mem_write) && !bridge_valid;
	assign pc_enable = !hold && !stall;
	assign d_enable = !hold && !stall;
	assign e_flush = stall && !hold;

	assign fwd_d1 = pick(d_instr.rs, e_c, m_c, w_c, 1'b1);
	assign fwd_d2 = pick(d_instr.rt, e_c, m_c, w_c, 1'b1);
	assign fwd_e1 = pick(e_instr.rs, e_c, m_c, w_c, 1'b0);
	assign fwd_e2 = pick(e_instr.rt, e_c, m_c, w_c, 1'b0);
	assign fwd_m = (m_c.mem_write && w_c.reg_write && w_c.dest == m_instr.rt) ?
		cpu_pkg::FWD_FROM_W : cpu_pkg::FWD_ORIG;

endmodule

// ==== design/cpu.sv ====
`timescale 1ns/1ps

module cpu (
	input logic clk,
	input logic reset,
	output logic [31:0] imem_addr,
	input logic [31:0] imem_data,
	output cpu_pkg::mem_req_t mem_req,
	input logic [31:0] mem_rdata,
	input logic bridge_valid,
	output cpu_pkg::wb_trace_t wb_trace
);

	function automatic logic [31:0] fwd_pick(cpu_pkg::fwd_sel_e sel, logic [31:0] orig,
		logic [31:0] from_e, logic [31:0] from_m, logic [31:0] from_w);
		case (sel)
			cpu_pkg::FWD_FROM_E: return from_e;
			cpu_pkg::FWD_FROM_M: return from_m;
			cpu_pkg::FWD_FROM_W: return from_w;
			default: return orig;
		endcase
	endfunction

	logic [31:0] pc, next_pc, pc_plus4;
	logic hold, pc_enable, d_enable, e_flush;
	cpu_pkg::fwd_sel_e fwd_d1, fwd_d2, fwd_e1, fwd_e2, fwd_m;
	cpu_pkg::ctrl_t e_ctrl;
	logic [2:0] jump_mode;

	cpu_pkg::dstage_t d_in, d_q;
	cpu_pkg::estage_t e_next, e_hold, e_in, e_q;
	cpu_pkg::mstage_t m_next, m_hold, m_in, m_q;
	cpu_pkg::wstage_t w_in, w_q;

	logic [31:0] rf_rdata1, rf_rdata2, d_op1, d_op2, d_imm, d_next_pc4;
	logic [31:0] e_op1, e_op2, e_alu_b, e_alu_result, e_retaddr;
	logic [31:0] m_result, store_data, w_data;
	logic zero_ext;

	control control (
		.d_instr(d_q.instr), .e_instr(e_q.instr), .m_instr(m_q.instr), .w_instr(w_q.instr),
		.bridge_valid(bridge_valid), .hold(hold), .pc_enable(pc_enable),
		.d_enable(d_enable), .e_flush(e_flush), .fwd_d1(fwd_d1), .fwd_d2(fwd_d2),
		.fwd_e1(fwd_e1), .fwd_e2(fwd_e2), .fwd_m(fwd_m), .e_ctrl(e_ctrl),
		.jump_mode(jump_mode)
	);

	// F
	assign pc_plus4 = pc + 32'd4;
	assign d_next_pc4 = d_q.pc + 32'd4;

	always_comb begin
		case (jump_mode)
			cpu_pkg::JMP_BEQ: next_pc = (d_op1 == d_op2) ?
				d_next_pc4 + {d_imm[29:0], 2'b00} : pc_plus4;
			cpu_pkg::JMP_BNE: next_pc = (d_op1 != d_op2) ?
				d_next_pc4 + {d_imm[29:0], 2'b00} : pc_plus4;
			cpu_pkg::JMP_J: next_pc = {d_next_pc4[31:28], d_q.instr[25:0], 2'b00};
			cpu_pkg::JMP_JR: next_pc = d_op1;
			default: next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= cpu_pkg::reset_pc;
		end else if (pc_enable) begin
			pc <= next_pc;
		end
	end

	assign imem_addr = pc;
	assign d_in = '{pc: pc, instr: imem_data};

	pipe_reg #(.payload_t(cpu_pkg::dstage_t)) d_reg (
		.clk(clk), .reset(reset), .enable(d_enable), .flush(1'b0), .d(d_in), .q(d_q)
	);

	// D
	regfile regfile (
		.clk(clk), .reset(reset), .raddr1(d_q.instr.rs), .raddr2(d_q.instr.rt),
		.waddr(w_q.dest), .wdata(w_data), .we(w_q.reg_write),
		.rdata1(rf_rdata1), .rdata2(rf_rdata2)
	);

	assign zero_ext = d_q.instr.op == cpu_pkg::OP_ORI || d_q.instr.op == cpu_pkg::OP_LUI;
	assign d_imm = {zero_ext ? 16'h0 : {16{d_q.instr.rd[4]}}, d_q.instr.rd,
		d_q.instr.shamt, d_q.instr.funct};
	assign d_op1 = fwd_pick(fwd_d1, rf_rdata1, e_retaddr, m_result, w_data);
	assign d_op2 = fwd_pick(fwd_d2, rf_rdata2, e_retaddr, m_result, w_data);

	assign e_next = '{pc: d_q.pc, instr: d_q.instr, op1: d_op1, op2: d_op2,
		imm: d_imm, ctrl: e_ctrl};

	// A held stage keeps its forwarded operands while W turns into a bubble
	always_comb begin
		e_hold = e_q;
		e_hold.op1 = e_op1;
		e_hold.op2 = e_op2;
		m_hold = m_q;
		m_hold.store_data = store_data;
	end

	assign e_in = hold ? e_hold : e_next;

	pipe_reg #(.payload_t(cpu_pkg::estage_t)) e_reg (
		.clk(clk), .reset(reset), .enable(1'b1), .flush(e_flush), .d(e_in), .q(e_q)
	);

	// E
	assign e_retaddr = e_q.pc + 32'd8;
	assign e_op1 = fwd_pick(fwd_e1, e_q.op1, e_q.op1, m_result, w_data);
	assign e_op2 = fwd_pick(fwd_e2, e_q.op2, e_q.op2, m_result, w_data);
	assign e_alu_b = e_q.ctrl.alu_src ? e_q.imm : e_op2;

	alu alu (.a(e_op1), .b(e_alu_b), .op(e_q.ctrl.alu_op), .result(e_alu_result));

	assign m_next = '{pc: e_q.pc, instr: e_q.instr, alu_result: e_alu_result,
		store_data: e_op2, dest: e_q.ctrl.dest, wb_sel: e_q.ctrl.wb_sel,
		mem_read: e_q.ctrl.mem_read, mem_write: e_q.ctrl.mem_write,
		reg_write: e_q.ctrl.reg_write};
	assign m_in = hold ? m_hold : m_next;

	pipe_reg #(.payload_t(cpu_pkg::mstage_t)) m_reg (
		.clk(clk), .reset(reset), .enable(1'b1), .flush(1'b0), .d(m_in), .q(m_q)
	);

	// M
	assign m_result = (m_q.wb_sel == cpu_pkg::WB_RETADDR) ? m_q.pc + 32'd8 :
		(m_q.wb_sel == cpu_pkg::WB_MEM) ? mem_rdata : m_q.alu_result;
	assign store_data = fwd_pick(fwd_m, m_q.store_data, m_q.store_data, m_q.store_data, w_data);

	assign mem_req = '{addr: m_q.alu_result, wdata: store_data, we: m_q.mem_write,
		stop: m_q.mem_read | m_q.mem_write};

	assign w_in = '{pc: m_q.pc, instr: m_q.instr, alu_result: m_q.alu_result,
		load_data: mem_rdata, dest: m_q.dest, wb_sel: m_q.wb_sel, reg_write: m_q.reg_write};

	pipe_reg #(.payload_t(cpu_pkg::wstage_t)) w_reg (
		.clk(clk), .reset(reset), .enable(1'b1), .flush(hold), .d(w_in), .q(w_q)
	);

	// W
	assign w_data = (w_q.wb_sel == cpu_pkg::WB_RETADDR) ? w_q.pc + 32'd8 :
		(w_q.wb_sel == cpu_pkg::WB_MEM) ? w_q.load_data : w_q.alu_result;
	assign wb_trace = '{valid: w_q.reg_write, pc: w_q.pc, addr: w_q.dest, data: w_data};

	// Bridge request stays put until the access completes
	a_req_stable: assert property (@(posedge clk) disable iff (reset)
		mem_req.stop && !bridge_valid |=> $stable(mem_req));

endmodule

// ==== include/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int NUM_PROG = 31;
localparam int NUM_WB = 21;
localparam int NUM_STORE = 2;
localparam int NUM_MEM = 4; // Loads and stores that reach the bridge

// Program loaded at reset_pc, one word per entry
logic [31:0] program_rom [NUM_PROG] = '{
	32'h3401_0005, // 3000 ori   $1, $0, 0x5
	32'h3402_0003, // 3004 ori   $2, $0, 0x3
	32'h0022_1821, // 3008 addu  $3, $1, $2
	32'h0062_2023, // 300c subu  $4, $3, $2
	32'h3C05_1234, // 3010 lui   $5, 0x1234
	32'h34A5_5678, // 3014 ori   $5, $5, 0x5678
	32'h0083_302A, // 3018 slt   $6, $4, $3
	32'h24C7_FFFE, // 301c addiu $7, $6, -2
	32'h00E6_402A, // 3020 slt   $8, $7, $6
	32'h3409_0100, // 3024 ori   $9, $0, 0x100
	32'hAD25_0004, // 3028 sw    $5, 4($9)
	32'h8D2A_0004, // 302c lw    $10, 4($9)
	32'h0141_5821, // 3030 addu  $11, $10, $1
	32'hAD2B_0008, // 3034 sw    $11, 8($9)
	32'h1024_0002, // 3038 beq   $1, $4, 3044
	32'h240C_0407, // 303c addiu $12, $0, 0x407
	32'h340D_0BAD, // 3040 ori   $13, $0, 0xbad
	32'h1424_0002, // 3044 bne   $1, $4, 3050
	32'h240E_0009, // 3048 addiu $14, $0, 9
	32'h340F_00FF, // 304c ori   $15, $0, 0xff
	32'h15E1_0002, // 3050 bne   $15, $1, 305c
	32'h01E1_8021, // 3054 addu  $16, $15, $1
	32'h3411_0BAD, // 3058 ori   $17, $0, 0xbad
	32'h0C00_0C1C, // 305c jal   3070
	32'h2412_0011, // 3060 addiu $18, $0, 0x11
	32'h025F_9821, // 3064 addu  $19, $18, $31
	32'h0800_0C1A, // 3068 j     3068
	32'h0000_0000, // 306c nop
	32'h8D34_0008, // 3070 lw    $20, 8($9)
	32'h03E0_0008, // 3074 jr    $31
	32'h0294_A821  // 3078 addu  $21, $20, $20
};

// Columns: valid, pc, destination register, written value
cpu_pkg::wb_trace_t wb_table [NUM_WB] = '{
	{1'b1, 32'h0000_3000, 5'd1, 32'h0000_0005},
	{1'b1, 32'h0000_3004, 5'd2, 32'h0000_0003},
	{1'b1, 32'h0000_3008, 5'd3, 32'h0000_0008},
	{1'b1, 32'h0000_300C, 5'd4, 32'h0000_0005},
	{1'b1, 32'h0000_3010, 5'd5, 32'h1234_0000},
	{1'b1, 32'h0000_3014, 5'd5, 32'h1234_5678},
	{1'b1, 32'h0000_3018, 5'd6, 32'h0000_0001},
	{1'b1, 32'h0000_301C, 5'd7, 32'hFFFF_FFFF},
	{1'b1, 32'h0000_3020, 5'd8, 32'h0000_0001}, // Signed compare of -1 and 1
	{1'b1, 32'h0000_3024, 5'd9, 32'h0000_0100},
	{1'b1, 32'h0000_302C, 5'd10, 32'h1234_5678},
	{1'b1, 32'h0000_3030, 5'd11, 32'h1234_567D},
	{1'b1, 32'h0000_303C, 5'd12, 32'h0000_0407}, // Bit 10 set but positive
	{1'b1, 32'h0000_3048, 5'd14, 32'h0000_0009},
	{1'b1, 32'h0000_304C, 5'd15, 32'h0000_00FF},
	{1'b1, 32'h0000_3054, 5'd16, 32'h0000_0104},
	{1'b1, 32'h0000_305C, 5'd31, 32'h0000_3064}, // jal link is its pc plus 8
	{1'b1, 32'h0000_3060, 5'd18, 32'h0000_0011},
	{1'b1, 32'h0000_3070, 5'd20, 32'h1234_567D},
	{1'b1, 32'h0000_3078, 5'd21, 32'h2468_ACFA},
	{1'b1, 32'h0000_3064, 5'd19, 32'h0000_3075}
};

// Columns: address, write data, write enable, stop
cpu_pkg::mem_req_t store_table [NUM_STORE] = '{
	{32'h0000_0104, 32'h1234_5678, 1'b1, 1'b1},
	{32'h0000_0108, 32'h1234_567D, 1'b1, 1'b1}
};

`endif

// ==== testbench/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;

	`include "tb_program.svh"

	localparam int DMEM_WORDS = 256;
	localparam int TIMEOUT_CYCLES = 4 + 20 * NUM_WB + 3 * NUM_MEM;

	logic clk;
	logic reset;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	cpu_pkg::mem_req_t mem_req;
	logic [31:0] mem_rdata;
	logic bridge_valid;
	cpu_pkg::wb_trace_t wb_trace;

	logic [31:0] dmem [DMEM_WORDS];
	int wb_idx = 0;
	int store_idx = 0;
	int mismatches = 0;
	int faults = 0;
	int wait_left = 0;
	logic busy = 1'b0;

	cpu UUT (
		.clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
		.mem_req(mem_req), .mem_rdata(mem_rdata), .bridge_valid(bridge_valid),
		.wb_trace(wb_trace)
	);

	function automatic logic [31:0] fetch_word(logic [31:0] addr);
		logic [31:0] offset;
		int slot;
		offset = addr - cpu_pkg::reset_pc;
		slot = int'(offset >> 2);
		if (offset[1:0] != 2'b00 || offset >= 32'(4 * NUM_PROG)) begin
			return 32'h0; // Outside the program reads as nop
		end
		return program_rom[slot];
	endfunction

	assign imem_data = fetch_word(imem_addr); // Instruction port answers in the same cycle

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_trace(input cpu_pkg::wb_trace_t got, input cpu_pkg::wb_trace_t exp);
		if (got !== exp) begin
			$display("Mismatch wb_trace: got %h/%h/%h/%h, expected %h/%h/%h/%h (valid/pc/reg/data)",
				got.valid, got.pc, got.addr, got.data, exp.valid, exp.pc, exp.addr, exp.data);
			mismatches++;
		end
	endtask

	task automatic check_mem(input cpu_pkg::mem_req_t got, input cpu_pkg::mem_req_t exp);
		if (got !== exp) begin
			$display("Mismatch mem_req: got %h/%h/%h/%h, expected %h/%h/%h/%h (addr/wdata/we/stop)",
				got.addr, got.wdata, got.we, got.stop, exp.addr, exp.wdata, exp.we, exp.stop);
			mismatches++;
		end
	endtask

	task automatic serve_access();
		if (mem_req.addr >= 32'(4 * DMEM_WORDS) || mem_req.addr[1:0] != 2'b00) begin
			$display("Bridge access to unmapped or unaligned address %h", mem_req.addr);
			faults++;
		end else if (mem_req.we) begin
			if (store_idx < NUM_STORE) begin
				check_mem(mem_req, store_table[store_idx]);
			end else begin
				$display("Unexpected store of %h to address %h", mem_req.wdata, mem_req.addr);
				faults++;
			end
			store_idx++;
			dmem[mem_req.addr[9:2]] = mem_req.wdata;
		end else begin
			mem_rdata = dmem[mem_req.addr[9:2]];
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] = 32'hC0DE_0000 + 32'(i * 4); // Each word carries its byte address
		end
	end

	// Bridge answers each access after 0 to 3 wait cycles
	always @(posedge clk) begin
		#1;
		if (bridge_valid) begin
			bridge_valid = 1'b0; // Access completed on this edge
			busy = 1'b0;
		end
		if (!reset && mem_req.stop) begin
			if (!busy) begin
				busy = 1'b1;
				wait_left = $urandom % 4;
			end
			if (wait_left == 0) begin
				serve_access();
				bridge_valid = 1'b1;
			end else begin
				wait_left--;
			end
		end
	end

	initial begin
		void'($urandom(68));
		reset = 1'b1;
		bridge_valid = 1'b0;
		mem_rdata = 32'h0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		check_word("imem_addr", imem_addr, cpu_pkg::reset_pc);
		check_mem(mem_req, '0);
		check_trace(wb_trace, '0);
		while (wb_idx < NUM_WB) begin
			@(negedge clk);
			if (wb_trace.valid) begin
				check_trace(wb_trace, wb_table[wb_idx]);
				wb_idx++;
			end
		end
		// Program ends in a jump to itself, nothing more may commit
		repeat (8) begin
			@(negedge clk);
			if (wb_trace.valid) begin
				$display("Unexpected register write to r%0d from pc %h", wb_trace.addr, wb_trace.pc);
				faults++;
			end
		end
		if (store_idx != NUM_STORE) begin
			$display("Saw %0d stores on the bridge where %0d were due", store_idx, NUM_STORE);
			faults++;
		end
		$display("Error count: %0d mismatches, %0d other failures", mismatches, faults);
		if (mismatches == 0 && faults == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles with %0d of %0d register writes seen",
			TIMEOUT_CYCLES, wb_idx, NUM_WB);
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+include
design/cpu_pkg.sv
design/pipe_reg.sv
design/regfile.sv
design/alu.sv
design/control.sv
design/cpu.sv
testbench/tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS = --binary --timing --assert -j 0
TOP = tb_cpu
FILELIST = tb.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then exit 1; fi
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
